//--- project.f
verilog/pad_pkg.sv
verilog/pad_bus_if.sv
verilog/pad_ring.sv
verilog/jtag_overlay_mux.sv
verilog/usb_swap_undo.sv
verilog/pad_ctrl_regs.sv
verilog/board_io_top.sv
testbench/io_checker.sv
testbench/tb_board_io.sv

//--- testbench/board_io_stim.txt
# Hex fields. W addr data resp | R addr data resp | P mio_in dio_in tdo
# E mio_out mio_oe dio_out dio_oe jtag, with jtag as {tck,tms,tdi,trst_n}
E 00 00 00 00 0
W 00 a5 0
R 00 a5 0
W 04 0f 0
R 04 0f 0
W 08 31 0
W 0c 0f 0
R 08 31 0
R 0c 0f 0
W 18 30f 0
R 18 30f 0
E aa 0f 32 0f 0
P 3c 50 0
R 10 33 0
R 14 53 0
R 1c 0 2
W 1c 12345678 2
W 10 ff 2
R 00 a5 0
R 18 30f 0
E aa 0f 32 0f 0
W 18 0 0
P c0 07 1
E a5 0f 39 08 f
R 14 02 0
R 10 80 0
P 80 05 0
E a5 0f 31 08 a
P 00 07 1
E a5 0f 31 0f 0
R 14 07 0
W 08 51 0
E a5 0f 51 0f 0
W 0c 9f 0
E a5 0f a1 6f 0
P 00 50 0
R 14 60 0
W 0c 0f 0
E a5 0f 51 0f 0
R 14 50 0

//--- testbench/io_checker.sv
/* Compares DUT responses and pad ports against driver expectations.
   AXI protocol rules are checked on every falling clock edge. */

module io_checker (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Observed DUT ports
  input  logic                          awready_i,
  input  logic                          wready_i,
  input  logic                          bvalid_i,
  input  logic                          bready_i,
  input  logic [1:0]                    bresp_i,
  input  logic                          arready_i,
  input  logic                          rvalid_i,
  input  logic                          rready_i,
  input  logic [pad_pkg::DataW-1:0]     rdata_i,
  input  logic [1:0]                    rresp_i,
  input  logic [pad_pkg::NumMioPads-1:0] mio_out_i,
  input  logic [pad_pkg::NumMioPads-1:0] mio_oe_i,
  input  logic [pad_pkg::NumDioPads-1:0] dio_out_i,
  input  logic [pad_pkg::NumDioPads-1:0] dio_oe_i,
  input  logic [3:0]                    jtag_i,
  // Expectation from the driver
  input  int                            chk_seq_i,
  input  logic [7:0]                    exp_kind_i,
  input  logic [1:0]                    exp_resp_i,
  input  logic [31:0]                   exp_data_i,
  input  logic [7:0]                    exp_mio_out_i,
  input  logic [7:0]                    exp_mio_oe_i,
  input  logic [7:0]                    exp_dio_out_i,
  input  logic [7:0]                    exp_dio_oe_i,
  input  logic [3:0]                    exp_jtag_i,
  output int                            checks_o,
  output int                            value_errs_o,
  output int                            proto_errs_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Last completed responses
  logic [1:0]               last_bresp, last_rresp;
  logic [pad_pkg::DataW-1:0] last_rdata;
  // Response seen waiting on the previous falling edge
  logic                     b_wait, r_wait;
  logic [1:0]               b_resp_q, r_resp_q;
  logic [pad_pkg::DataW-1:0] r_data_q;

  initial begin
    checks_o     = 0;
    value_errs_o = 0;
    proto_errs_o = 0;
    b_wait       = 1'b0;
    r_wait       = 1'b0;
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks_o++;
    if (exp !== act) begin
      value_errs_o++;
      $display("CHECK FAILED at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic protocol_error(input string what);
    proto_errs_o++;
    $display("Protocol error at %0t ns: %s", $time, what);
  endtask

  ////////////////////
  // AXI protocol
  ////////////////////
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (awready_i !== wready_i) begin
        protocol_error("awready and wready differ");
      end
      if (bvalid_i && awready_i) begin
        protocol_error("a write was taken while a write response waited");
      end
      if (rvalid_i && arready_i) begin
        protocol_error("a read was taken while read data waited");
      end
      if (b_wait && (!bvalid_i || bresp_i !== b_resp_q)) begin
        protocol_error("the write response changed while bready was low");
      end
      if (r_wait && (!rvalid_i || rdata_i !== r_data_q || rresp_i !== r_resp_q)) begin
        protocol_error("the read response changed while rready was low");
      end
      // Completes on the next rising edge
      if (bvalid_i && bready_i) begin
        last_bresp = bresp_i;
      end
      if (rvalid_i && rready_i) begin
        last_rdata = rdata_i;
        last_rresp = rresp_i;
      end
    end
    b_wait   = rst_n_i && bvalid_i && !bready_i;
    b_resp_q = bresp_i;
    r_wait   = rst_n_i && rvalid_i && !rready_i;
    r_data_q = rdata_i;
    r_resp_q = rresp_i;
  end

  ////////////////////
  // Driver requests
  ////////////////////
  always @(chk_seq_i) begin
    if (chk_seq_i > 0) begin
      case (exp_kind_i)
        "W": compare("bresp_o", exp_resp_i, last_bresp);
        "R": begin
          compare("rdata_o", exp_data_i, last_rdata);
          compare("rresp_o", exp_resp_i, last_rresp);
        end
        default: begin
          compare("mio_out_o", exp_mio_out_i, mio_out_i);
          compare("mio_oe_o", exp_mio_oe_i, mio_oe_i);
          compare("dio_out_o", exp_dio_out_i, dio_out_i);
          compare("dio_oe_o", exp_dio_oe_i, dio_oe_i);
          compare("jtag tck,tms,tdi,trst_n", exp_jtag_i, jtag_i);
        end
      endcase
    end
  end

endmodule : io_checker

//--- testbench/tb_board_io.sv
/* Testbench for board_io_top. Operations and expected values come from
   testbench/board_io_stim.txt, so the run must start in the project root. */

module tb_board_io;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string StimFile  = "testbench/board_io_stim.txt";
  localparam int    ClkPeriod = 40;

  logic                          clk_main_i;
  logic                          rst_n_i;
  logic [pad_pkg::NumMioPads-1:0] mio_in_i, mio_out_o, mio_oe_o;
  logic [pad_pkg::NumDioPads-1:0] dio_in_i, dio_out_o, dio_oe_o;
  logic                          jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o;
  logic                          jtag_tdo_i;
  logic [pad_pkg::AddrW-1:0]     awaddr_i, araddr_i;
  logic [pad_pkg::DataW-1:0]     wdata_i, rdata_o;
  logic                          awvalid_i, awready_o, wvalid_i, wready_o;
  logic                          bvalid_o, bready_i, arvalid_i, arready_o;
  logic                          rvalid_o, rready_i;
  logic [1:0]                    bresp_o, rresp_o;

  // Expectation for the checker, each new chk_seq value is one request
  int          chk_seq = 0;
  logic [7:0]  exp_kind;
  logic [1:0]  exp_resp;
  logic [31:0] exp_data;
  logic [7:0]  exp_mio_out, exp_mio_oe, exp_dio_out, exp_dio_oe;
  logic [3:0]  exp_jtag;
  int          checks, value_errs, proto_errs;
  int          stim_errs = 0;
  int          seed = 67;

  board_io_top board_io_top_i (.*);

  io_checker u_io_checker (
    .clk_i         (clk_main_i),
    .rst_n_i       (rst_n_i),
    .awready_i     (awready_o),
    .wready_i      (wready_o),
    .bvalid_i      (bvalid_o),
    .bready_i      (bready_i),
    .bresp_i       (bresp_o),
    .arready_i     (arready_o),
    .rvalid_i      (rvalid_o),
    .rready_i      (rready_i),
    .rdata_i       (rdata_o),
    .rresp_i       (rresp_o),
    .mio_out_i     (mio_out_o),
    .mio_oe_i      (mio_oe_o),
    .dio_out_i     (dio_out_o),
    .dio_oe_i      (dio_oe_o),
    .jtag_i        ({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o}),
    .chk_seq_i     (chk_seq),
    .exp_kind_i    (exp_kind),
    .exp_resp_i    (exp_resp),
    .exp_data_i    (exp_data),
    .exp_mio_out_i (exp_mio_out),
    .exp_mio_oe_i  (exp_mio_oe),
    .exp_dio_out_i (exp_dio_out),
    .exp_dio_oe_i  (exp_dio_oe),
    .exp_jtag_i    (exp_jtag),
    .checks_o      (checks),
    .value_errs_o  (value_errs),
    .proto_errs_o  (proto_errs)
  );

  initial begin
    clk_main_i = 1'b0;
  end

  always #(ClkPeriod / 2) clk_main_i = ~clk_main_i;

  task automatic random_wait(input int max_cycles);
    repeat ($unsigned($random(seed)) % max_cycles) @(posedge clk_main_i);
  endtask

  task automatic axi_write(input logic [pad_pkg::AddrW-1:0] addr,
                           input logic [pad_pkg::DataW-1:0] data);
    @(posedge clk_main_i);
    awaddr_i  <= addr;
    wdata_i   <= data;
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    do @(negedge clk_main_i); while (!awready_o);
    // Request stays up while bready is held low
    do @(negedge clk_main_i); while (!bvalid_o);
    random_wait(4);
    @(posedge clk_main_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    bready_i  <= 1'b1;
    @(posedge clk_main_i);
    bready_i  <= 1'b0;
  endtask

  task automatic axi_read(input logic [pad_pkg::AddrW-1:0] addr);
    @(posedge clk_main_i);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    do @(negedge clk_main_i); while (!arready_o);
    do @(negedge clk_main_i); while (!rvalid_o);
    random_wait(4);
    @(posedge clk_main_i);
    arvalid_i <= 1'b0;
    rready_i  <= 1'b1;
    @(posedge clk_main_i);
    rready_i  <= 1'b0;
  endtask

  task automatic send_expect();
    @(negedge clk_main_i);
    chk_seq++;
  endtask

  task automatic report_bad_line(input logic [7:0] kind);
    stim_errs++;
    $display("Stimulus line of kind %c has missing or unreadable fields", kind);
  endtask

  task automatic run_stim(input int fd);
    int               code;
    logic [7:0]       kind;
    logic [31:0]      f1, f2, f3, f4, f5;
    logic [8*128-1:0] line;
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": code = $fgets(line, fd);
        "W", "R": begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (code != 3) begin
            report_bad_line(kind);
          end else if (kind == "W") begin
            axi_write(f1[pad_pkg::AddrW-1:0], f2);
          end else begin
            axi_read(f1[pad_pkg::AddrW-1:0]);
          end
          exp_kind = kind;
          exp_data = f2;
          exp_resp = f3[1:0];
          send_expect();
        end
        "P": begin
          code = $fscanf(fd, "%h %h %h", f1, f2, f3);
          if (code != 3) begin
            report_bad_line(kind);
          end
          @(posedge clk_main_i);
          mio_in_i   <= f1[pad_pkg::NumMioPads-1:0];
          dio_in_i   <= f2[pad_pkg::NumDioPads-1:0];
          jtag_tdo_i <= f3[0];
          repeat (pad_pkg::SyncStages + 2) @(posedge clk_main_i);
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
          if (code != 5) begin
            report_bad_line(kind);
          end
          exp_kind    = kind;
          exp_mio_out = f1[7:0];
          exp_mio_oe  = f2[7:0];
          exp_dio_out = f3[7:0];
          exp_dio_oe  = f4[7:0];
          exp_jtag    = f5[3:0];
          send_expect();
        end
        default: begin
          stim_errs++;
          $display("Unknown operation %c in the stimulus file", kind);
        end
      endcase
      random_wait(3);
    end
  endtask

  initial begin : driver
    int fd;
    rst_n_i    = 1'b0;
    mio_in_i   = '0;
    dio_in_i   = '0;
    jtag_tdo_i = 1'b0;
    awaddr_i   = '0;
    awvalid_i  = 1'b0;
    wdata_i    = '0;
    wvalid_i   = 1'b0;
    bready_i   = 1'b0;
    araddr_i   = '0;
    arvalid_i  = 1'b0;
    rready_i   = 1'b0;
    repeat (3) @(posedge clk_main_i);
    rst_n_i <= 1'b1;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", StimFile);
      $display("=== FAIL ===");
      $finish;
    end else begin
      run_stim(fd);
      $fclose(fd);
      repeat (2) @(posedge clk_main_i);
      $display("Done: %0d checks, %0d value errors, %0d protocol errors, %0d stimulus errors",
               checks, value_errs, proto_errs, stim_errs);
      if (checks > 0 && value_errs == 0 && proto_errs == 0 && stim_errs == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

  // Time budget of 20 cycles per stimulus line
  initial begin : watchdog
    int               fd;
    int               n_lines;
    logic [8*128-1:0] line;
    n_lines = 1;
    fd = $fopen(StimFile, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n_lines++;
      end
      $fclose(fd);
    end
    #(n_lines * 20 * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", n_lines * 20);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_board_io

//--- verilog/board_io_top.sv
/* Board I/O subsystem top. No inout pins, no clock generation.
   Dedicated chain: regs, USB swap, JTAG mux, pad ring. */

module board_io_top (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  // Pads
  input  logic [pad_pkg::NumMioPads-1:0] mio_in_i,
  output logic [pad_pkg::NumMioPads-1:0] mio_out_o,
  output logic [pad_pkg::NumMioPads-1:0] mio_oe_o,
  input  logic [pad_pkg::NumDioPads-1:0] dio_in_i,
  output logic [pad_pkg::NumDioPads-1:0] dio_out_o,
  output logic [pad_pkg::NumDioPads-1:0] dio_oe_o,
  // JTAG
  output logic                          jtag_tck_o,
  output logic                          jtag_tms_o,
  output logic                          jtag_tdi_o,
  output logic                          jtag_trst_n_o,
  input  logic                          jtag_tdo_i,
  // AXI4-Lite slave
  input  logic [pad_pkg::AddrW-1:0]     awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [pad_pkg::DataW-1:0]     wdata_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [pad_pkg::AddrW-1:0]     araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [pad_pkg::DataW-1:0]     rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i
);

  // One bus per hop between stages
  pad_bus_if #(.NumPads(pad_pkg::NumMioPads)) mio_core_bus ();
  pad_bus_if #(.NumPads(pad_pkg::NumMioPads)) mio_ring_bus ();
  pad_bus_if #(.NumPads(pad_pkg::NumDioPads)) dio_core_bus ();
  pad_bus_if #(.NumPads(pad_pkg::NumDioPads)) dio_umux_bus ();
  pad_bus_if #(.NumPads(pad_pkg::NumDioPads)) dio_ring_bus ();

  pad_ctrl_regs u_pad_ctrl_regs (
    .clk_main_i, .rst_n_i,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .mio_if (mio_core_bus),
    .dio_if (dio_core_bus)
  );

  usb_swap_undo u_usb_swap_undo (
    .core_if (dio_core_bus),
    .ring_if (dio_umux_bus)
  );

  jtag_overlay_mux u_jtag_overlay_mux (
    .mio_core_if (mio_core_bus),
    .dio_core_if (dio_umux_bus),
    .mio_ring_if (mio_ring_bus),
    .dio_ring_if (dio_ring_bus),
    .jtag_tck_o, .jtag_tms_o, .jtag_tdi_o, .jtag_trst_n_o, .jtag_tdo_i
  );

  pad_ring #(.NumPads(pad_pkg::NumMioPads)) u_mio_ring (
    .clk_main_i, .rst_n_i,
    .pad_in_i  (mio_in_i),
    .pad_out_o (mio_out_o),
    .pad_oe_o  (mio_oe_o),
    .bus_if    (mio_ring_bus)
  );

  pad_ring #(.NumPads(pad_pkg::NumDioPads)) u_dio_ring (
    .clk_main_i, .rst_n_i,
    .pad_in_i  (dio_in_i),
    .pad_out_o (dio_out_o),
    .pad_oe_o  (dio_oe_o),
    .bus_if    (dio_ring_bus)
  );

endmodule : board_io_top

//--- verilog/jtag_overlay_mux.sv
/* Hands the SPI pads and muxed pad 6 to JTAG while the synchronized strap
   is high. JTAG levels are passed through unclocked. */

module jtag_overlay_mux (
  pad_bus_if.ring mio_core_if,
  pad_bus_if.ring dio_core_if,
  pad_bus_if.core mio_ring_if,
  pad_bus_if.core dio_ring_if,
  output logic    jtag_tck_o,
  output logic    jtag_tms_o,
  output logic    jtag_tdi_o,
  output logic    jtag_trst_n_o,
  input  logic    jtag_tdo_i
);

  logic jtag_en;

  // Strap comes from the ring side already synchronized and inverted
  assign jtag_en = mio_ring_if.in[pad_pkg::MioJtagEn];

  ////////////////////
  // Muxed pads
  ////////////////////
  assign mio_ring_if.out = mio_core_if.out;
  assign mio_ring_if.oe  = mio_core_if.oe;
  assign mio_ring_if.inv = mio_core_if.inv;

  always_comb begin
    mio_core_if.in = mio_ring_if.in;
    if (jtag_en) begin
      mio_core_if.in[pad_pkg::MioJtagTrstN] = 1'b0;
    end
  end

  ////////////////////
  // Dedicated pads
  ////////////////////
  always_comb begin
    dio_ring_if.out = dio_core_if.out;
    dio_ring_if.oe  = dio_core_if.oe;
    if (jtag_en) begin
      // TDO drives out on the SDO pad
      dio_ring_if.out[pad_pkg::DioSpiSdo] = jtag_tdo_i;
      dio_ring_if.oe[pad_pkg::DioSpiSdo]  = 1'b1;
      dio_ring_if.oe[pad_pkg::DioSpiSck]  = 1'b0;
      dio_ring_if.oe[pad_pkg::DioSpiCsb]  = 1'b0;
      dio_ring_if.oe[pad_pkg::DioSpiSdi]  = 1'b0;
    end
  end

  assign dio_ring_if.inv = dio_core_if.inv;

  // Core SPI inputs go quiet while JTAG owns the pins
  always_comb begin
    dio_core_if.in = dio_ring_if.in;
    if (jtag_en) begin
      dio_core_if.in[pad_pkg::DioSpiSck] = 1'b0;
      dio_core_if.in[pad_pkg::DioSpiCsb] = pad_pkg::JtagTieOffCsb;
      dio_core_if.in[pad_pkg::DioSpiSdi] = 1'b0;
    end
  end

  // JTAG side held at 0 when disabled so TAP reset stays asserted
  assign jtag_tck_o    = jtag_en & dio_ring_if.in[pad_pkg::DioSpiSck];
  assign jtag_tms_o    = jtag_en & dio_ring_if.in[pad_pkg::DioSpiCsb];
  assign jtag_tdi_o    = jtag_en & dio_ring_if.in[pad_pkg::DioSpiSdi];
  assign jtag_trst_n_o = jtag_en & mio_ring_if.in[pad_pkg::MioJtagTrstN];

endmodule : jtag_overlay_mux

//--- verilog/pad_bus_if.sv
/* Lanes of one pad bank between two stages. The core side drives
   out, oe and inv and the ring side returns the pad inputs. */

interface pad_bus_if #(
  parameter int NumPads = 8
);

  logic [NumPads-1:0] out;
  logic [NumPads-1:0] oe;
  logic [NumPads-1:0] in;
  logic [NumPads-1:0] inv;

  modport core (
    output out, oe, inv,
    input  in
  );

  modport ring (
    input  out, oe, inv,
    output in
  );

endinterface : pad_bus_if

//--- verilog/pad_ctrl_regs.sv
/* AXI4-Lite slave without prot or strobes; one outstanding read and one
   outstanding write. Unmapped or read-only writes answer SLVERR. */

module pad_ctrl_regs (
  input  logic                      clk_main_i,
  input  logic                      rst_n_i,
  // Write address and data
  input  logic [pad_pkg::AddrW-1:0] awaddr_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [pad_pkg::DataW-1:0] wdata_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  // Write response
  output logic [1:0]                bresp_o,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  // Read
  input  logic [pad_pkg::AddrW-1:0] araddr_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  output logic [pad_pkg::DataW-1:0] rdata_o,
  output logic [1:0]                rresp_o,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  // Pad lanes
  pad_bus_if.core                   mio_if,
  pad_bus_if.core                   dio_if
);

  logic [pad_pkg::NumMioPads-1:0] mio_out_q, mio_oe_q;
  logic [pad_pkg::NumDioPads-1:0] dio_out_q, dio_oe_q;
  // Muxed pads in the low byte, dedicated pads above
  logic [pad_pkg::NumDioPads+pad_pkg::NumMioPads-1:0] invert_q;

  logic                      wr_fire, wr_err, bvalid_q;
  logic [1:0]                bresp_q;
  logic                      rd_fire, rd_err, rvalid_q;
  logic [1:0]                rresp_q;
  logic [pad_pkg::DataW-1:0] rd_data, rdata_q;

  ////////////////////
  // Write channel
  ////////////////////
  assign wr_fire = awvalid_i & wvalid_i & ~bvalid_q;

  always_comb begin
    case (awaddr_i)
      pad_pkg::RegMioOut, pad_pkg::RegMioOe, pad_pkg::RegDioOut,
      pad_pkg::RegDioOe, pad_pkg::RegInvert: wr_err = 1'b0;
      default: wr_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      mio_out_q <= '0;
      mio_oe_q  <= '0;
      dio_out_q <= '0;
      dio_oe_q  <= '0;
      invert_q  <= '0;
      bvalid_q  <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
      case (awaddr_i)
        pad_pkg::RegMioOut: mio_out_q <= wdata_i[pad_pkg::NumMioPads-1:0];
        pad_pkg::RegMioOe:  mio_oe_q  <= wdata_i[pad_pkg::NumMioPads-1:0];
        pad_pkg::RegDioOut: dio_out_q <= wdata_i[pad_pkg::NumDioPads-1:0];
        pad_pkg::RegDioOe:  dio_oe_q  <= wdata_i[pad_pkg::NumDioPads-1:0];
        pad_pkg::RegInvert: invert_q  <= wdata_i[$bits(invert_q)-1:0];
        default: ;
      endcase
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (wr_fire) begin
      bresp_q <= wr_err ? pad_pkg::RespSlvErr : pad_pkg::RespOkay;
    end
  end

  ////////////////////
  // Read channel
  ////////////////////
  assign rd_fire = arvalid_i & ~rvalid_q;

  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (araddr_i)
      pad_pkg::RegMioOut: rd_data[pad_pkg::NumMioPads-1:0] = mio_out_q;
      pad_pkg::RegMioOe:  rd_data[pad_pkg::NumMioPads-1:0] = mio_oe_q;
      pad_pkg::RegDioOut: rd_data[pad_pkg::NumDioPads-1:0] = dio_out_q;
      pad_pkg::RegDioOe:  rd_data[pad_pkg::NumDioPads-1:0] = dio_oe_q;
      pad_pkg::RegMioIn:  rd_data[pad_pkg::NumMioPads-1:0] = mio_if.in;
      pad_pkg::RegDioIn:  rd_data[pad_pkg::NumDioPads-1:0] = dio_if.in;
      pad_pkg::RegInvert: rd_data[$bits(invert_q)-1:0]     = invert_q;
      default:            rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? pad_pkg::RespSlvErr : pad_pkg::RespOkay;
    end
  end

  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = bresp_q;
  assign arready_o = ~rvalid_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = rresp_q;

  // Register state straight onto the lanes
  assign mio_if.out = mio_out_q;
  assign mio_if.oe  = mio_oe_q;
  assign mio_if.inv = invert_q[pad_pkg::NumMioPads-1:0];
  assign dio_if.out = dio_out_q;
  assign dio_if.oe  = dio_oe_q;
  assign dio_if.inv = invert_q[pad_pkg::NumMioPads +: pad_pkg::NumDioPads];

  // Responses hold steady under back-pressure
  bvalid_hold: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    bvalid_q && !bready_i |=> bvalid_q && $stable(bresp_q));

  rvalid_hold: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    rvalid_q && !rready_i |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule : pad_ctrl_regs

//--- verilog/pad_pkg.sv
/* Pad counts, pin indices, register map and AXI4-Lite response codes.
   Register addresses are byte addresses and must be word aligned. */

package pad_pkg;

  ////////////////////
  // Pad bank sizes
  ////////////////////
  localparam int NumMioPads = 8;
  localparam int NumDioPads = 8;

  // Dedicated pad indices
  localparam int DioSpiSck      = 0;
  localparam int DioSpiCsb      = 1;
  localparam int DioSpiSdi      = 2;
  localparam int DioSpiSdo      = 3;
  localparam int DioUsbDp       = 4;
  localparam int DioUsbDn       = 5;
  localparam int DioUsbDpPullup = 6;
  localparam int DioUsbDnPullup = 7;

  // Muxed pads with a JTAG role, strap is active high
  localparam int MioJtagEn    = 7;
  localparam int MioJtagTrstN = 6;

  // CSB is active low, so the core sees it idle while JTAG owns it
  localparam logic JtagTieOffCsb = 1'b1;

  // Input synchronizer depth
  localparam int SyncStages = 2;

  ////////////////////
  // Register map
  ////////////////////
  localparam int AddrW = 5;
  localparam int DataW = 32;

  localparam logic [AddrW-1:0] RegMioOut = 5'h00;
  localparam logic [AddrW-1:0] RegMioOe  = 5'h04;
  localparam logic [AddrW-1:0] RegDioOut = 5'h08;
  localparam logic [AddrW-1:0] RegDioOe  = 5'h0C;
  localparam logic [AddrW-1:0] RegMioIn  = 5'h10;
  localparam logic [AddrW-1:0] RegDioIn  = 5'h14;
  localparam logic [AddrW-1:0] RegInvert = 5'h18;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

endpackage : pad_pkg

//--- verilog/pad_ring.sv
/* Pad bank model with split in, out and oe in place of inout pins.
   Inversion is the only pad attribute and oe is never inverted. */

module pad_ring #(
  parameter int NumPads = 8
) (
  input  logic               clk_main_i,
  input  logic               rst_n_i,
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  pad_bus_if.ring            bus_if
);

  // Stage 0 samples the pad, the last stage feeds the core
  logic [NumPads-1:0] sync_q [pad_pkg::SyncStages];

  ////////////////////
  // Input path
  ////////////////////
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < pad_pkg::SyncStages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= pad_in_i;
      for (int i = 1; i < pad_pkg::SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Inversion after the synchronizer
  assign bus_if.in = sync_q[pad_pkg::SyncStages-1] ^ bus_if.inv;

  ////////////////////
  // Output path
  ////////////////////
  assign pad_out_o = bus_if.out ^ bus_if.inv;
  assign pad_oe_o  = bus_if.oe;

endmodule : pad_ring

//--- verilog/usb_swap_undo.sv
/* Undoes a D+/D- pin flip done by the USB core. The flip is signalled by
   the DN pullup oe. Pullup inputs are never swapped. */

module usb_swap_undo (
  pad_bus_if.ring core_if,
  pad_bus_if.core ring_if
);

  logic undo_swap;

  // Exchange two bits of a lane when requested
  function automatic logic [pad_pkg::NumDioPads-1:0] swap_bits(
    input logic [pad_pkg::NumDioPads-1:0] vec,
    input int                             a,
    input int                             b,
    input logic                           en
  );
    logic [pad_pkg::NumDioPads-1:0] res;
    res = vec;
    if (en) begin
      res[a] = vec[b];
      res[b] = vec[a];
    end
    return res;
  endfunction

  assign undo_swap = core_if.oe[pad_pkg::DioUsbDnPullup];

  always_comb begin
    ring_if.out = swap_bits(core_if.out, pad_pkg::DioUsbDp, pad_pkg::DioUsbDn, undo_swap);
    ring_if.out = swap_bits(ring_if.out, pad_pkg::DioUsbDpPullup, pad_pkg::DioUsbDnPullup,
                            undo_swap);
    ring_if.oe  = swap_bits(core_if.oe, pad_pkg::DioUsbDp, pad_pkg::DioUsbDn, undo_swap);
    ring_if.oe  = swap_bits(ring_if.oe, pad_pkg::DioUsbDpPullup, pad_pkg::DioUsbDnPullup,
                            undo_swap);
    ring_if.inv = swap_bits(core_if.inv, pad_pkg::DioUsbDp, pad_pkg::DioUsbDn, undo_swap);
    ring_if.inv = swap_bits(ring_if.inv, pad_pkg::DioUsbDpPullup, pad_pkg::DioUsbDnPullup,
                            undo_swap);
  end

  // Only the data lines come back swapped
  assign core_if.in = swap_bits(ring_if.in, pad_pkg::DioUsbDp, pad_pkg::DioUsbDn, undo_swap);

endmodule : usb_swap_undo
